// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_mock_mmu
FILELIST ?= files.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -j 0
PASS_MSG ?= Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	-$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Test failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: boot_loader.sv
`timescale 1ns/1ps
`default_nettype none

module boot_loader (
   input  wire logic                                clk_i,
   input  wire logic                                reset_i,
   output logic      [mmu_pkg::BOOT_ADDR_WIDTH-1:0] boot_addr_o,
   output logic                                     boot_we_o,
   output logic                                     boot_done_o
);
   import mmu_pkg::*;

   logic [BOOT_ADDR_WIDTH-1:0] el_cnt;
   logic done_r;
   logic last_el;

   assign last_el = (el_cnt == BOOT_ADDR_WIDTH'(BOOT_ROM_ELS - 1));

   // One element per cycle until the whole image is in RAM
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         el_cnt <= '0;
         done_r <= 1'b0;
      end else if (!done_r) begin
         el_cnt <= el_cnt + 1'b1;
         if (last_el) begin
            done_r <= 1'b1;
         end
      end
   end

   assign boot_addr_o = el_cnt;
   assign boot_we_o = ~done_r;
   assign boot_done_o = done_r;

endmodule

`default_nettype wire

// File: boot_rom.sv
`timescale 1ns/1ps
`default_nettype none

module boot_rom (
   input  wire logic [mmu_pkg::BOOT_ADDR_WIDTH-1:0] boot_addr_i,
   output mmu_pkg::mmu_word_u                       boot_data_o
);
   import mmu_pkg::*;

   mmu_word_u rom [BOOT_ROM_ELS];

   // Byte k of element e is the low byte of (8e+k)*29+17
   function automatic mmu_word_u rom_element(int e);
      mmu_word_u w;
      for (int k = 0; k < BOOT_LANES; k++) begin
         w.lanes[k] = BYTE_WIDTH'((BOOT_LANES * e + k) * ROM_MUL + ROM_ADD);
      end
      return w;
   endfunction

   for (genvar e = 0; e < BOOT_ROM_ELS; e++) begin : g_rom
      assign rom[e] = rom_element(e);
   end

   assign boot_data_o = rom[boot_addr_i];

endmodule

`default_nettype wire

// File: files.f
mmu_pkg.sv
mmu_cmd_if.sv
boot_rom.sv
boot_loader.sv
mmu_hit_pipe.sv
mmu_miss_timer.sv
mock_dmem.sv
mock_mmu_top.sv
tb_mock_mmu.sv

// File: mmu_cmd_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mmu_cmd_if;
   import mmu_pkg::*;

   logic valid;
   mmu_op_e op;
   logic [MEM_ADDR_WIDTH-1:0] addr;
   logic [DATA_WIDTH-1:0] data;

   modport source (
      output valid,
      output op,
      output addr,
      output data
   );

   modport sink (
      input valid,
      input op,
      input addr,
      input data
   );

endinterface

`default_nettype wire

// File: mmu_hit_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module mmu_hit_pipe (
   input  wire logic                               clk_i,
   input  wire logic                               reset_i,
   input  wire logic                               cmd_v_i,
   input  mmu_pkg::mmu_op_e                        cmd_op_i,
   input  wire logic [mmu_pkg::MEM_ADDR_WIDTH-1:0] cmd_addr_i,
   input  wire logic [mmu_pkg::DATA_WIDTH-1:0]     cmd_data_i,
   input  wire logic                               cmd_rdy_i,
   input  wire logic                               flush_i,
   mmu_cmd_if.source                               out
);
   import mmu_pkg::*;

   logic [HIT_STAGES-1:0] v_r;
   logic [HIT_STAGES-1:0] psn_r;
   mmu_op_e op_r [HIT_STAGES];
   logic [MEM_ADDR_WIDTH-1:0] addr_r [HIT_STAGES];
   logic [DATA_WIDTH-1:0] data_r [HIT_STAGES];
   logic accept;

   assign accept = cmd_v_i & cmd_rdy_i;

   // Flush hits the entry entering stage 0 and the one leaving it
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         v_r <= '0;
         psn_r <= '0;
      end else begin
         v_r[0] <= accept;
         psn_r[0] <= flush_i;
         for (int i = 1; i < HIT_STAGES; i++) begin
            v_r[i] <= v_r[i-1];
            psn_r[i] <= psn_r[i-1] | (flush_i & (i == 1));
         end
      end
   end

   always_ff @(posedge clk_i) begin
      op_r[0] <= cmd_op_i;
      addr_r[0] <= cmd_addr_i;
      data_r[0] <= cmd_data_i;
      for (int i = 1; i < HIT_STAGES; i++) begin
         op_r[i] <= op_r[i-1];
         addr_r[i] <= addr_r[i-1];
         data_r[i] <= data_r[i-1];
      end
   end

   assign out.valid = v_r[HIT_STAGES-1] & ~psn_r[HIT_STAGES-1];
   assign out.op = op_r[HIT_STAGES-1];
   assign out.addr = addr_r[HIT_STAGES-1];
   assign out.data = data_r[HIT_STAGES-1];

endmodule

`default_nettype wire

// File: mmu_miss_timer.sv
`timescale 1ns/1ps
`default_nettype none

module mmu_miss_timer (
   input  wire logic clk_i,
   input  wire logic reset_i,
   input  wire logic boot_done_i,
   mmu_cmd_if.sink   cmd,
   output logic      miss_o,
   output logic      cmd_rdy_o
);
   import mmu_pkg::*;

   logic [MISS_CNT_WIDTH-1:0] resp_cnt;
   logic [WIN_CNT_WIDTH-1:0] win_cnt;
   logic win_active;
   logic counted;
   logic period_hit;

   assign win_active = (win_cnt != '0);

   // Responses inside a stall window are not counted
   assign counted = cmd.valid & ~win_active;
   assign period_hit = counted & (resp_cnt == MISS_CNT_WIDTH'(MISS_PERIOD - 1));

   assign miss_o = period_hit | (cmd.valid & win_active);
   assign cmd_rdy_o = boot_done_i & ~win_active;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         resp_cnt <= '0;
         win_cnt <= '0;
      end else if (period_hit) begin
         // Window covers the next MISS_LATENCY-1 cycles
         resp_cnt <= '0;
         win_cnt <= WIN_CNT_WIDTH'(MISS_LATENCY - 1);
      end else begin
         if (counted) begin
            resp_cnt <= resp_cnt + 1'b1;
         end
         if (win_active) begin
            win_cnt <= win_cnt - 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// File: mmu_pkg.sv
`default_nettype none

package mmu_pkg;

   // Register and memory geometry
   localparam int DATA_WIDTH = 64;
   localparam int BYTE_WIDTH = 8;
   localparam int HWORD_WIDTH = 16;
   localparam int WORD_WIDTH = 32;
   localparam int BYTES_PER_WORD = DATA_WIDTH / BYTE_WIDTH;
   localparam int LEN_WIDTH = $clog2(BYTES_PER_WORD) + 1;

   localparam int MEM_BYTES = 256;
   localparam int MEM_ADDR_WIDTH = 8;

   // Boot image
   localparam int BOOT_ROM_ELS = 32;
   localparam int BOOT_ROM_WIDTH = 64;
   localparam int BOOT_ADDR_WIDTH = 5;
   localparam int BOOT_LANES = BOOT_ROM_WIDTH / BYTE_WIDTH;
   localparam int ROM_MUL = 29;
   localparam int ROM_ADD = 17;

   // Pipeline and miss emulation timing
   localparam int HIT_LATENCY = 3;
   localparam int HIT_STAGES = HIT_LATENCY - 1;
   localparam int MISS_PERIOD = 4;
   localparam int MISS_CNT_WIDTH = $clog2(MISS_PERIOD);
   localparam int MISS_LATENCY = 8;
   localparam int WIN_CNT_WIDTH = $clog2(MISS_LATENCY);

   localparam int OP_WIDTH = 4;

   // Codes 7 and 12..15 are invalid
   typedef enum logic [OP_WIDTH-1:0] {
      e_lb  = 4'd0,
      e_lh  = 4'd1,
      e_lw  = 4'd2,
      e_ld  = 4'd3,
      e_lbu = 4'd4,
      e_lhu = 4'd5,
      e_lwu = 4'd6,
      e_sb  = 4'd8,
      e_sh  = 4'd9,
      e_sw  = 4'd10,
      e_sd  = 4'd11
   } mmu_op_e;

   // Lane 0 is the least significant byte
   typedef union packed {
      logic [DATA_WIDTH-1:0] dword;
      logic [BYTES_PER_WORD-1:0][BYTE_WIDTH-1:0] lanes;
   } mmu_word_u;

endpackage

`default_nettype wire

// File: mock_dmem.sv
`timescale 1ns/1ps
`default_nettype none

module mock_dmem (
   input  wire logic                                clk_i,
   input  wire logic                                boot_we_i,
   input  wire logic [mmu_pkg::BOOT_ADDR_WIDTH-1:0] boot_addr_i,
   input  mmu_pkg::mmu_word_u                       boot_data_i,
   mmu_cmd_if.sink                                  cmd,
   input  wire logic                                miss_i,
   output mmu_pkg::mmu_word_u                       resp_data_o
);
   import mmu_pkg::*;

   logic [BYTE_WIDTH-1:0] mem [MEM_BYTES];

   logic [MEM_ADDR_WIDTH-1:0] lane_addr [BYTES_PER_WORD];
   logic [MEM_ADDR_WIDTH-1:0] boot_base;
   mmu_word_u st_word;
   mmu_word_u ld_word;
   logic [LEN_WIDTH-1:0] st_len;
   logic st_en;

   // Number of byte lanes a store writes or zero for any other op
   function automatic logic [LEN_WIDTH-1:0] store_len(mmu_op_e op);
      case (op)
         e_sb:    store_len = LEN_WIDTH'(1);
         e_sh:    store_len = LEN_WIDTH'(2);
         e_sw:    store_len = LEN_WIDTH'(4);
         e_sd:    store_len = LEN_WIDTH'(8);
         default: store_len = '0;
      endcase
   endfunction

   assign boot_base = MEM_ADDR_WIDTH'(boot_addr_i) << $clog2(BOOT_LANES);
   assign st_word.dword = cmd.data;
   assign st_len = store_len(cmd.op);
   assign st_en = cmd.valid & ~miss_i & (st_len != '0);

   // Lane addresses wrap at the end of the RAM
   always_comb begin
      for (int k = 0; k < BYTES_PER_WORD; k++) begin
         lane_addr[k] = cmd.addr + MEM_ADDR_WIDTH'(k);
      end
   end

   always_ff @(posedge clk_i) begin
      if (boot_we_i) begin
         for (int k = 0; k < BOOT_LANES; k++) begin
            mem[boot_base + MEM_ADDR_WIDTH'(k)] <= boot_data_i.lanes[k];
         end
      end else if (st_en) begin
         for (int k = 0; k < BYTES_PER_WORD; k++) begin
            if (k < int'(st_len)) begin
               mem[lane_addr[k]] <= st_word.lanes[k];
            end
         end
      end
   end

   // Little-endian gather of the eight bytes at addr
   always_comb begin
      for (int k = 0; k < BYTES_PER_WORD; k++) begin
         ld_word.lanes[k] = mem[lane_addr[k]];
      end
   end

   always_comb begin
      case (cmd.op)
         e_lb: resp_data_o.dword = {{(DATA_WIDTH - BYTE_WIDTH){ld_word.dword[BYTE_WIDTH-1]}},
                                    ld_word.dword[BYTE_WIDTH-1:0]};
         e_lh: resp_data_o.dword = {{(DATA_WIDTH - HWORD_WIDTH){ld_word.dword[HWORD_WIDTH-1]}},
                                    ld_word.dword[HWORD_WIDTH-1:0]};
         e_lw: resp_data_o.dword = {{(DATA_WIDTH - WORD_WIDTH){ld_word.dword[WORD_WIDTH-1]}},
                                    ld_word.dword[WORD_WIDTH-1:0]};
         e_ld: resp_data_o.dword = ld_word.dword;
         e_lbu: resp_data_o.dword = {{(DATA_WIDTH - BYTE_WIDTH){1'b0}},
                                     ld_word.dword[BYTE_WIDTH-1:0]};
         e_lhu: resp_data_o.dword = {{(DATA_WIDTH - HWORD_WIDTH){1'b0}},
                                     ld_word.dword[HWORD_WIDTH-1:0]};
         e_lwu: resp_data_o.dword = {{(DATA_WIDTH - WORD_WIDTH){1'b0}},
                                     ld_word.dword[WORD_WIDTH-1:0]};
         // Stores and invalid codes return zero
         default: resp_data_o.dword = '0;
      endcase
   end

endmodule

`default_nettype wire

// File: mock_mmu_top.sv
`timescale 1ns/1ps
`default_nettype none

module mock_mmu_top (
   input  wire logic                               clk_i,
   input  wire logic                               reset_i,
   input  wire logic                               cmd_v_i,
   input  mmu_pkg::mmu_op_e                        cmd_op_i,
   input  wire logic [mmu_pkg::MEM_ADDR_WIDTH-1:0] cmd_addr_i,
   input  wire logic [mmu_pkg::DATA_WIDTH-1:0]     cmd_data_i,
   output logic                                    cmd_rdy_o,
   input  wire logic                               flush_i,
   output logic                                    resp_v_o,
   output logic      [mmu_pkg::DATA_WIDTH-1:0]     resp_data_o,
   output logic                                    resp_miss_o
);
   import mmu_pkg::*;

   logic [BOOT_ADDR_WIDTH-1:0] boot_addr;
   logic boot_we;
   logic boot_done;
   mmu_word_u boot_data;
   mmu_word_u resp_data;
   logic cmd_rdy;
   logic miss;

   mmu_cmd_if cmd_bus ();

   boot_rom boot_rom_inst (
      .boot_addr_i (boot_addr),
      .boot_data_o (boot_data)
   );

   boot_loader boot_loader_inst (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .boot_addr_o (boot_addr),
      .boot_we_o   (boot_we),
      .boot_done_o (boot_done)
   );

   mmu_hit_pipe mmu_hit_pipe_inst (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .cmd_v_i    (cmd_v_i),
      .cmd_op_i   (cmd_op_i),
      .cmd_addr_i (cmd_addr_i),
      .cmd_data_i (cmd_data_i),
      .cmd_rdy_i  (cmd_rdy),
      .flush_i    (flush_i),
      .out        (cmd_bus.source)
   );

   mmu_miss_timer mmu_miss_timer_inst (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .boot_done_i (boot_done),
      .cmd         (cmd_bus.sink),
      .miss_o      (miss),
      .cmd_rdy_o   (cmd_rdy)
   );

   mock_dmem mock_dmem_inst (
      .clk_i       (clk_i),
      .boot_we_i   (boot_we),
      .boot_addr_i (boot_addr),
      .boot_data_i (boot_data),
      .cmd         (cmd_bus.sink),
      .miss_i      (miss),
      .resp_data_o (resp_data)
   );

   assign cmd_rdy_o = cmd_rdy;
   assign resp_v_o = cmd_bus.valid;
   assign resp_miss_o = miss;
   assign resp_data_o = resp_data.dword;

endmodule

`default_nettype wire

// File: tb_mock_mmu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mock_mmu;
   import mmu_pkg::*;

   localparam int MAX_CYCLES = 5000;
   localparam int WAIT_LIMIT = 100;
   localparam int RANDOM_CYCLES = 400;

   typedef struct packed {
      int cycle;
      logic [OP_WIDTH-1:0] op;
      logic [MEM_ADDR_WIDTH-1:0] addr;
      logic [DATA_WIDTH-1:0] data;
   } issue_t;

   logic clk_i;
   logic reset_i;
   logic cmd_v;
   mmu_op_e cmd_op;
   logic [MEM_ADDR_WIDTH-1:0] cmd_addr;
   logic [DATA_WIDTH-1:0] cmd_data;
   logic cmd_rdy;
   logic flush;
   logic resp_v;
   logic [DATA_WIDTH-1:0] resp_data;
   logic resp_miss;

   logic [BYTE_WIDTH-1:0] model_mem [MEM_BYTES];
   issue_t issue_q [$];
   logic [31:0] lfsr_state = 32'd80523;
   logic flush_d1 = 1'b0;
   logic flush_d2 = 1'b0;
   int cyc = 0;
   int boot_cnt = 0;
   int win_m = 0;
   int cnt_m = 0;
   int stores_written = 0;
   int stores_dropped = 0;
   int flushed_cnt = 0;

   mock_mmu_top mock_mmu_top_inst (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .cmd_v_i     (cmd_v),
      .cmd_op_i    (cmd_op),
      .cmd_addr_i  (cmd_addr),
      .cmd_data_i  (cmd_data),
      .cmd_rdy_o   (cmd_rdy),
      .flush_i     (flush),
      .resp_v_o    (resp_v),
      .resp_data_o (resp_data),
      .resp_miss_o (resp_miss)
   );

   initial begin
      clk_i = 1'b0;
      forever #5 clk_i = ~clk_i;
   end

   // Cycle count, boot progress and flush history as seen at each rising edge
   always @(posedge clk_i) begin
      cyc <= cyc + 1;
      flush_d1 <= flush;
      flush_d2 <= flush_d1;
      if (reset_i) begin
         boot_cnt <= 0;
      end else if (boot_cnt < BOOT_ROM_ELS) begin
         boot_cnt <= boot_cnt + 1;
      end
   end

   task automatic abort_run(string why);
      $display("%s", why);
      $display("Simulation finished: FAIL");
      $fatal(1, "Run stopped");
   endtask

   task automatic check_value(string what, logic [63:0] got, logic [63:0] exp);
      if (got !== exp) begin
         $display("Fail at time %0t: %s is %h, expected %h", $time, what, got, exp);
         abort_run("Output mismatch");
      end
   endtask

   // Right-shifting Galois LFSR with taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   function automatic logic [63:0] rand_bits(int n);
      logic [63:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         r = {r[62:0], lfsr_state[0]};
      end
      return r;
   endfunction

   function automatic logic [7:0] rom_byte(int i);
      return 8'((i * 29 + 17) % 256);
   endfunction

   function automatic int store_bytes(logic [3:0] op);
      case (op)
         e_sb: return 1;
         e_sh: return 2;
         e_sw: return 4;
         e_sd: return 8;
         default: return 0;
      endcase
   endfunction

   function automatic logic [63:0] ref_load(logic [3:0] op, logic [7:0] addr);
      logic [63:0] raw;
      raw = '0;
      for (int i = 0; i < 8; i++) begin
         raw[8*i +: 8] = model_mem[(int'(addr) + i) % MEM_BYTES];
      end
      case (op)
         e_lb:  return 64'($signed(raw[7:0]));
         e_lh:  return 64'($signed(raw[15:0]));
         e_lw:  return 64'($signed(raw[31:0]));
         e_ld:  return raw;
         e_lbu: return 64'(raw[7:0]);
         e_lhu: return 64'(raw[15:0]);
         e_lwu: return 64'(raw[31:0]);
         default: return '0;
      endcase
   endfunction

   task automatic apply_store(logic [3:0] op, logic [7:0] addr, logic [63:0] data);
      for (int i = 0; i < store_bytes(op); i++) begin
         model_mem[(int'(addr) + i) % MEM_BYTES] = data[8*i +: 8];
      end
   endtask

   // Reference model and per-cycle compare on the falling edge
   initial begin : compare_proc
      issue_t ent;
      logic has;
      logic v;
      logic win_act;
      logic counted;
      logic period;
      logic miss_exp;
      for (int i = 0; i < MEM_BYTES; i++) begin
         model_mem[i] = rom_byte(i);
      end
      forever begin
         @(negedge clk_i);
         if (cyc > MAX_CYCLES) begin
            abort_run("Simulation ran past its cycle limit");
         end
         win_act = (win_m != 0);
         check_value("cmd_rdy_o", 64'(cmd_rdy), 64'((boot_cnt == BOOT_ROM_ELS) && !win_act));
         has = (issue_q.size() != 0) && (issue_q[0].cycle == cyc - 2);
         ent = '0;
         if (has) begin
            ent = issue_q.pop_front();
         end
         v = has && !(flush_d1 || flush_d2);
         if (has && !v) begin
            flushed_cnt++;
         end
         check_value("resp_v_o", 64'(resp_v), 64'(v));
         counted = v && !win_act;
         period = counted && (cnt_m == MISS_PERIOD - 1);
         miss_exp = period || (v && win_act);
         check_value("resp_miss_o", 64'(resp_miss), 64'(miss_exp));
         if (v) begin
            check_value("resp_data_o", resp_data, ref_load(ent.op, ent.addr));
            if (store_bytes(ent.op) != 0 && miss_exp) begin
               stores_dropped++;
            end else if (store_bytes(ent.op) != 0) begin
               apply_store(ent.op, ent.addr, ent.data);
               stores_written++;
            end
         end
         if (period) begin
            cnt_m = 0;
            win_m = MISS_LATENCY - 1;
         end else begin
            if (counted) begin
               cnt_m++;
            end
            if (win_act) begin
               win_m--;
            end
         end
      end
   end

   // Drives one cycle and records the command if it will be accepted
   task automatic apply_inputs(logic v, logic [3:0] op, logic [7:0] addr,
                               logic [63:0] data, logic fl);
      issue_t ent;
      cmd_v = v;
      cmd_op = mmu_op_e'(op);
      cmd_addr = addr;
      cmd_data = data;
      flush = fl;
      if (v && cmd_rdy === 1'b1) begin
         ent.cycle = cyc;
         ent.op = op;
         ent.addr = addr;
         ent.data = data;
         issue_q.push_back(ent);
      end
   endtask

   task automatic idle_cycles(int n, logic fl);
      repeat (n) begin
         @(negedge clk_i);
         apply_inputs(1'b0, e_ld, '0, '0, fl);
      end
   endtask

   task automatic send_cmd(logic [3:0] op, logic [7:0] addr, logic [63:0] data, logic fl);
      int tries;
      tries = 0;
      forever begin
         @(negedge clk_i);
         if (cmd_rdy === 1'b1) begin
            apply_inputs(1'b1, op, addr, data, fl);
            return;
         end
         apply_inputs(1'b0, op, addr, data, 1'b0);
         tries++;
         if (tries > WAIT_LIMIT) begin
            abort_run("A command was never accepted because cmd_rdy_o stayed low");
         end
      end
   endtask

   initial begin : drive_proc
      int low_cycles;
      reset_i = 1'b1;
      cmd_v = 1'b0;
      cmd_op = e_ld;
      cmd_addr = '0;
      cmd_data = '0;
      flush = 1'b0;
      repeat (3) @(posedge clk_i);
      low_cycles = 0;
      forever begin
         @(negedge clk_i);
         reset_i = 1'b0;
         if (cmd_rdy === 1'b1) begin
            break;
         end
         low_cycles++;
         if (low_cycles > WAIT_LIMIT) begin
            abort_run("cmd_rdy_o never rose after the boot copy");
         end
      end
      check_value("boot stall cycles", 64'(low_cycles), 64'(BOOT_ROM_ELS));

      // Whole boot image, back to back
      for (int a = 0; a < BOOT_ROM_ELS; a++) begin
         send_cmd(e_ld, 8'(8 * a), '0, 1'b0);
      end
      idle_cycles(4, 1'b0);

      // Every non-store code on a positive byte, a negative byte and a wrapping address
      for (int a = 0; a < 3; a++) begin
         for (int c = 0; c < 16; c++) begin
            if (store_bytes(4'(c)) == 0) begin
               send_cmd(4'(c), (a == 2) ? 8'hFD : 8'(4 * a), '0, 1'b0);
            end
         end
      end
      idle_cycles(4, 1'b0);

      // Each store width, then LD around it, once mid-RAM and once across the top
      for (int a = 0; a < 2; a++) begin
         for (int c = 0; c < 16; c++) begin
            if (store_bytes(4'(c)) != 0) begin
               send_cmd(4'(c), (a == 0) ? 8'h80 : 8'hFD, 64'hF0E1_D2C3_B4A5_9687 ^ 64'(c), 1'b0);
               send_cmd(e_ld, (a == 0) ? 8'h80 : 8'hF8, '0, 1'b0);
               send_cmd(e_ld, (a == 0) ? 8'h7C : 8'h00, '0, 1'b0);
            end
         end
      end
      idle_cycles(4, 1'b0);

      // Back-to-back stores then loads to open several stall windows
      for (int a = 0; a < 12; a++) begin
         send_cmd(e_sd, 8'(16 + 8 * a), {32'h5A5A_0000, 32'(a)}, 1'b0);
      end
      for (int a = 0; a < 12; a++) begin
         send_cmd(e_ld, 8'(16 + 8 * a), '0, 1'b0);
      end
      idle_cycles(4, 1'b0);

      // Flush together with a command, and a flush on its own
      for (int a = 0; a < 3; a++) begin
         send_cmd(e_sd, 8'(48 + 16 * a), 64'h1111_2222_3333_4444, 1'b0);
         send_cmd(e_sd, 8'(56 + 16 * a), 64'h5555_6666_7777_8888, 1'b1);
         send_cmd(e_ld, 8'(48 + 16 * a), '0, 1'b0);
         send_cmd(e_ld, 8'(56 + 16 * a), '0, 1'b0);
         send_cmd(e_sw, 8'(48 + 16 * a), 64'h9999_AAAA_BBBB_CCCC, 1'b0);
         idle_cycles(1, 1'b1);
         send_cmd(e_ld, 8'(48 + 16 * a), '0, 1'b0);
         idle_cycles(2, 1'b0);
      end

      for (int a = 0; a < RANDOM_CYCLES; a++) begin
         @(negedge clk_i);
         apply_inputs(rand_bits(2) != '0, 4'(rand_bits(4)), 8'(rand_bits(8)),
                      rand_bits(64), rand_bits(4) == '0);
      end
      idle_cycles(HIT_LATENCY + 3, 1'b0);

      check_value("commands still in flight", 64'(issue_q.size()), 64'd0);
      check_value("stores written", 64'(stores_written > 0), 64'd1);
      check_value("stores dropped on a miss", 64'(stores_dropped > 0), 64'd1);
      check_value("flushed commands", 64'(flushed_cnt > 0), 64'd1);
      $display("Simulation finished: PASS");
      $finish;
   end

endmodule

`default_nettype wire
